// File: verilog/pov_pkg.sv
package pov_pkg;

    // Display geometry at the reduced size of this build
    parameter int NUM_LANES     = 4;
    parameter int LED_PER_LANE  = 4;
    parameter int MULTIPLEXING  = 4;
    parameter int SLICES_IN_RAM = 4;

    // Nine planes per column keep the driver in its 9-bit grey-scale frame
    parameter int PLANES       = 9;
    // Only the five upper planes carry colour bits, the rest are sent as zero
    parameter int COLOR_PLANES = 5;

    // One slice holds every column of every LED of every lane
    parameter int SLICE_WORDS = MULTIPLEXING * NUM_LANES * LED_PER_LANE;
    parameter int RAM_WORDS   = SLICE_WORDS * SLICES_IN_RAM;
    parameter int RAM_ADDR_W  = $clog2(RAM_WORDS);

    // Red in bits 4..0, green in bits 9..5 and blue in bits 14..10
    typedef logic [14:0] pixel_t;

    typedef logic [RAM_ADDR_W-1:0] ram_addr_t;

    // Three bits per LED, ordered red, green, blue from the low end
    typedef logic [3*LED_PER_LANE-1:0] plane_t;

    typedef logic [$clog2(MULTIPLEXING)-1:0]  column_idx_t;
    typedef logic [3:0]                       plane_idx_t;
    typedef logic [$clog2(SLICES_IN_RAM)-1:0] slice_idx_t;

    typedef enum logic [1:0] {
        IDLE,
        FETCH,
        SEND,
        SWAP
    } sched_state_t;

endpackage

// File: verilog/pov_ifs.sv
// Write path from the column fetcher into the back buffers of all lanes
interface lane_fill_if #(
    parameter int NUM_LANES    = pov_pkg::NUM_LANES,
    parameter int LED_PER_LANE = pov_pkg::LED_PER_LANE
);
    import pov_pkg::*;

    localparam int LANE_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;
    localparam int LED_W  = (LED_PER_LANE > 1) ? $clog2(LED_PER_LANE) : 1;

    logic              wr_en;
    logic [LANE_W-1:0] wr_lane;
    logic [LED_W-1:0]  wr_led;
    pixel_t            wr_pixel;

    modport fetcher (output wr_en, wr_lane, wr_led, wr_pixel);
    modport lane    (input wr_en, wr_lane, wr_led, wr_pixel);

endinterface

// Plane selection and buffer control from the scheduler, planes back from the lanes
interface plane_bus_if #(
    parameter int NUM_LANES = pov_pkg::NUM_LANES
);
    import pov_pkg::*;

    plane_idx_t plane_sel;
    logic       swap;
    logic       slice_start;
    // Every lane drives only its own element
    plane_t     planes [NUM_LANES];

    modport scheduler (output plane_sel, swap, slice_start, input planes);
    modport lane      (input plane_sel, swap, slice_start, output planes);

endinterface

// File: verilog/slice_ram.sv
module slice_ram #(
    parameter int WORDS = pov_pkg::RAM_WORDS
) (
    input  logic               clk,
    input  logic               wr_en,
    input  pov_pkg::ram_addr_t wr_addr,
    input  pov_pkg::pixel_t    wr_data,
    input  pov_pkg::ram_addr_t rd_addr,
    output pov_pkg::pixel_t    rd_data
);
    import pov_pkg::*;

    // Image storage, one pixel per word, laid out slice by slice
    pixel_t mem [WORDS];

    // The host fills the memory through this port before streaming starts
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Registered read port, so data arrives one cycle after the address
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// File: verilog/column_fetcher.sv
module column_fetcher #(
    parameter int NUM_LANES    = pov_pkg::NUM_LANES,
    parameter int LED_PER_LANE = pov_pkg::LED_PER_LANE
) (
    input  logic                 clk,
    input  logic                 nrst,
    input  logic                 stream_ready,
    input  logic                 fetch_start,
    input  pov_pkg::column_idx_t fetch_column,
    input  pov_pkg::slice_idx_t  fetch_slice,
    output logic                 fill_done,
    output pov_pkg::ram_addr_t   rd_addr,
    input  pov_pkg::pixel_t      rd_data,
    lane_fill_if.fetcher         fill
);
    import pov_pkg::*;

    // Words of one column across all lanes
    localparam int COL_WORDS = NUM_LANES * LED_PER_LANE;
    localparam int WORD_W    = (COL_WORDS > 1) ? $clog2(COL_WORDS) : 1;
    localparam int LANE_W    = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;
    localparam int LED_W     = (LED_PER_LANE > 1) ? $clog2(LED_PER_LANE) : 1;

    ram_addr_t         start_base;
    ram_addr_t         base_q;
    logic [WORD_W-1:0] word_cnt;
    logic              active;
    logic [WORD_W-1:0] rd_word;
    logic              rd_issue;
    logic              wr_en_q;
    logic [WORD_W-1:0] tag_q;

    // Base of the requested column following the RAM layout rule
    assign start_base = ram_addr_t'(fetch_slice * SLICE_WORDS + fetch_column * COL_WORDS);

    // The first read goes out in the cycle of fetch_start itself
    assign rd_word  = fetch_start ? '0 : word_cnt;
    assign rd_issue = stream_ready && (fetch_start || active);
    assign rd_addr  = fetch_start ? start_base : ram_addr_t'(base_q + word_cnt);

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            active    <= 1'b0;
            word_cnt  <= '0;
            wr_en_q   <= 1'b0;
            fill_done <= 1'b0;
        end else if (!stream_ready) begin
            // Abort the column and drop any reads in flight
            active  <= 1'b0;
            wr_en_q <= 1'b0;
        end else begin
            wr_en_q <= rd_issue;
            if (fetch_start) begin
                word_cnt  <= WORD_W'(1);
                active    <= (COL_WORDS > 1);
                fill_done <= 1'b0;
            end else if (active) begin
                word_cnt <= word_cnt + 1'b1;
                if (word_cnt == WORD_W'(COL_WORDS - 1)) begin
                    active <= 1'b0;
                end
            end
            // The last write lands in the lanes at this edge
            if (wr_en_q && tag_q == WORD_W'(COL_WORDS - 1)) begin
                fill_done <= 1'b1;
            end
        end
    end

    // Column base for the later reads and the word tag of each read in flight
    always_ff @(posedge clk) begin
        if (fetch_start) begin
            base_q <= start_base;
        end
        tag_q <= rd_word;
    end

    // The word tag splits into lane and LED because lanes are contiguous in the column
    assign fill.wr_en    = wr_en_q;
    assign fill.wr_lane  = LANE_W'(tag_q / LED_PER_LANE);
    assign fill.wr_led   = LED_W'(tag_q % LED_PER_LANE);
    assign fill.wr_pixel = rd_data;

endmodule

// File: verilog/pixel_lane.sv
module pixel_lane #(
    parameter int LANE_INDEX   = 0,
    parameter int LED_PER_LANE = pov_pkg::LED_PER_LANE
) (
    input  logic      clk,
    input  logic      nrst,
    lane_fill_if.lane fill,
    plane_bus_if.lane bus
);
    import pov_pkg::*;

    // Planes below this one are padding and carry no colour
    localparam int FIRST_COLOR_PLANE = PLANES - COLOR_PLANES;

    pixel_t     buf_a [LED_PER_LANE];
    pixel_t     buf_b [LED_PER_LANE];
    pixel_t     front [LED_PER_LANE];
    logic       front_sel;
    logic [2:0] color_bit;
    pixel_t     px;
    plane_t     plane_bits;

    // Buffer A is in front while front_sel is low
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            front_sel <= 1'b0;
        end else if (bus.slice_start) begin
            front_sel <= 1'b0;
        end else if (bus.swap) begin
            front_sel <= ~front_sel;
        end
    end

    // The fetcher only ever writes the back buffer of the addressed lane
    always_ff @(posedge clk) begin
        if (fill.wr_en && int'(fill.wr_lane) == LANE_INDEX) begin
            if (front_sel) begin
                buf_a[fill.wr_led] <= fill.wr_pixel;
            end else begin
                buf_b[fill.wr_led] <= fill.wr_pixel;
            end
        end
    end

    always_comb begin
        for (int led = 0; led < LED_PER_LANE; led++) begin
            front[led] = front_sel ? buf_b[led] : buf_a[led];
        end
    end

    // Plane 8 takes colour bit 4 and plane 4 takes colour bit 0
    assign color_bit = 3'(bus.plane_sel - FIRST_COLOR_PLANE);

    always_comb begin
        plane_bits = '0;
        px         = '0;
        if (int'(bus.plane_sel) >= FIRST_COLOR_PLANE) begin
            for (int led = 0; led < LED_PER_LANE; led++) begin
                px = front[led];
                plane_bits[3*led]     = px[color_bit];
                plane_bits[3*led + 1] = px[COLOR_PLANES + color_bit];
                plane_bits[3*led + 2] = px[2*COLOR_PLANES + color_bit];
            end
        end
    end

    assign bus.planes[LANE_INDEX] = plane_bits;

endmodule

// File: verilog/plane_scheduler.sv
module plane_scheduler #(
    parameter int NUM_LANES     = pov_pkg::NUM_LANES,
    parameter int MULTIPLEXING  = pov_pkg::MULTIPLEXING,
    parameter int SLICES_IN_RAM = pov_pkg::SLICES_IN_RAM
) (
    input  logic                            clk,
    input  logic                            nrst,
    input  logic                            stream_ready,
    input  logic                            driver_ready,
    input  logic                            position_sync,
    input  logic                            fill_done,
    output logic                            fetch_start,
    output pov_pkg::column_idx_t            fetch_column,
    output pov_pkg::slice_idx_t             fetch_slice,
    plane_bus_if.scheduler                  bus,
    output pov_pkg::plane_t [NUM_LANES-1:0] data_out,
    output logic                            data_valid
);
    import pov_pkg::*;

    localparam plane_idx_t TOP_PLANE = plane_idx_t'(PLANES - 1);

    sched_state_t state;
    column_idx_t  column;
    plane_idx_t   plane;
    slice_idx_t   slice;
    logic         start_slice;
    logic         last_column;
    logic         send_beat;

    // A new slice starts only on a sync pulse while the stream is up
    assign start_slice = (state == IDLE) && stream_ready && position_sync;
    assign last_column = (column == column_idx_t'(MULTIPLEXING - 1));
    assign send_beat   = (state == SEND) && stream_ready && driver_ready;

    assign bus.slice_start = start_slice;
    assign bus.swap        = (state == FETCH) && stream_ready && fill_done;
    assign bus.plane_sel   = plane;

    // Column 0 is fetched from IDLE, later columns are prefetched from SWAP
    assign fetch_start  = start_slice || ((state == SWAP) && stream_ready && !last_column);
    assign fetch_column = (state == SWAP) ? column_idx_t'(column + 1'b1) : column;
    assign fetch_slice  = slice;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state  <= IDLE;
            column <= '0;
            plane  <= TOP_PLANE;
            slice  <= '0;
        end else if (!stream_ready) begin
            // Drop the slice but keep its number so it is sent again
            state  <= IDLE;
            column <= '0;
            plane  <= TOP_PLANE;
        end else begin
            case (state)
                IDLE: begin
                    if (position_sync) begin
                        state <= FETCH;
                    end
                end
                FETCH: begin
                    // Waits here when the back buffer is not filled yet
                    if (fill_done) begin
                        state <= SWAP;
                    end
                end
                SWAP: begin
                    state <= SEND;
                end
                SEND: begin
                    if (driver_ready) begin
                        if (plane == '0) begin
                            plane <= TOP_PLANE;
                            if (last_column) begin
                                column <= '0;
                                state  <= IDLE;
                                if (slice == slice_idx_t'(SLICES_IN_RAM - 1)) begin
                                    slice <= '0;
                                end else begin
                                    slice <= slice + 1'b1;
                                end
                            end else begin
                                column <= column + 1'b1;
                                state  <= FETCH;
                            end
                        end else begin
                            plane <= plane - 1'b1;
                        end
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // One registered beat per plane, data_valid marks it for a single cycle
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            data_out   <= '0;
            data_valid <= 1'b0;
        end else begin
            data_valid <= send_beat;
            if (send_beat) begin
                for (int i = 0; i < NUM_LANES; i++) begin
                    data_out[i] <= bus.planes[i];
                end
            end
        end
    end

endmodule

// File: verilog/pov_framebuffer.sv
module pov_framebuffer #(
    parameter int NUM_LANES     = pov_pkg::NUM_LANES,
    parameter int LED_PER_LANE  = pov_pkg::LED_PER_LANE,
    parameter int MULTIPLEXING  = pov_pkg::MULTIPLEXING,
    parameter int SLICES_IN_RAM = pov_pkg::SLICES_IN_RAM
) (
    input  logic                            clk,
    input  logic                            nrst,
    input  logic                            wr_en,
    input  pov_pkg::ram_addr_t              wr_addr,
    input  pov_pkg::pixel_t                 wr_data,
    input  logic                            stream_ready,
    input  logic                            driver_ready,
    input  logic                            position_sync,
    output pov_pkg::plane_t [NUM_LANES-1:0] data_out,
    output logic                            data_valid
);
    import pov_pkg::*;

    // Every slice of the image is kept in the RAM at once
    localparam int WORDS = SLICES_IN_RAM * MULTIPLEXING * NUM_LANES * LED_PER_LANE;

    ram_addr_t   rd_addr;
    pixel_t      rd_data;
    logic        fetch_start;
    column_idx_t fetch_column;
    slice_idx_t  fetch_slice;
    logic        fill_done;

    lane_fill_if #(
        .NUM_LANES   (NUM_LANES),
        .LED_PER_LANE(LED_PER_LANE)
    ) fill_bus ();

    plane_bus_if #(
        .NUM_LANES(NUM_LANES)
    ) plane_bus ();

    slice_ram #(
        .WORDS(WORDS)
    ) u_ram (
        .clk    (clk),
        .wr_en  (wr_en),
        .wr_addr(wr_addr),
        .wr_data(wr_data),
        .rd_addr(rd_addr),
        .rd_data(rd_data)
    );

    column_fetcher #(
        .NUM_LANES   (NUM_LANES),
        .LED_PER_LANE(LED_PER_LANE)
    ) u_fetcher (
        .clk         (clk),
        .nrst        (nrst),
        .stream_ready(stream_ready),
        .fetch_start (fetch_start),
        .fetch_column(fetch_column),
        .fetch_slice (fetch_slice),
        .fill_done   (fill_done),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .fill        (fill_bus)
    );

    // One lane per LED driver, each picks its own writes off the shared bus
    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        pixel_lane #(
            .LANE_INDEX  (g),
            .LED_PER_LANE(LED_PER_LANE)
        ) u_lane (
            .clk (clk),
            .nrst(nrst),
            .fill(fill_bus),
            .bus (plane_bus)
        );
    end

    plane_scheduler #(
        .NUM_LANES    (NUM_LANES),
        .MULTIPLEXING (MULTIPLEXING),
        .SLICES_IN_RAM(SLICES_IN_RAM)
    ) u_scheduler (
        .clk          (clk),
        .nrst         (nrst),
        .stream_ready (stream_ready),
        .driver_ready (driver_ready),
        .position_sync(position_sync),
        .fill_done    (fill_done),
        .fetch_start  (fetch_start),
        .fetch_column (fetch_column),
        .fetch_slice  (fetch_slice),
        .bus          (plane_bus),
        .data_out     (data_out),
        .data_valid   (data_valid)
    );

endmodule

// File: tests/tb_pov_framebuffer.sv
module tb_pov_framebuffer;
    timeunit 1ns;
    timeprecision 100ps;

    import pov_pkg::*;

    // One beat carries the planes of all lanes side by side
    localparam int BEAT_W       = NUM_LANES * 3 * LED_PER_LANE;
    localparam int COL_WORDS    = NUM_LANES * LED_PER_LANE;
    localparam int SLICE_BEATS  = MULTIPLEXING * PLANES;
    localparam int RESET_CYCLES = 10;
    // Worst case of one slice with driver_ready held high, fetch plus swap plus planes
    localparam int SLICE_CYCLES = MULTIPLEXING * (COL_WORDS + 3 + PLANES) + 20;
    localparam int BEAT_LIMIT   = SLICE_CYCLES * 4;
    // Sum of the tests, the back-pressure slice counted three times over
    localparam int TEST_CYCLES  = 3 * (RESET_CYCLES + 1) + 50 + RAM_WORDS + 2
                                  + SLICE_CYCLES * (1 + 3 + 5 + 2) + 40;
    localparam int WATCHDOG_NS  = TEST_CYCLES * 2 * 10;

    logic                      clk;
    logic                      nrst;
    logic                      wr_en;
    ram_addr_t                 wr_addr;
    pixel_t                    wr_data;
    logic                      stream_ready;
    logic                      driver_ready;
    logic                      position_sync;
    plane_t [NUM_LANES-1:0]    data_out;
    logic                      data_valid;

    // Copy of every word the host has written into the slice RAM
    pixel_t            shadow [RAM_WORDS];
    logic [BEAT_W-1:0] beats [$];
    logic              ready_last;
    int                exp_slice;
    int                seed;
    int                value_errors;
    int                event_errors;

    pov_framebuffer dut (
        .clk          (clk),
        .nrst         (nrst),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .stream_ready (stream_ready),
        .driver_ready (driver_ready),
        .position_sync(position_sync),
        .data_out     (data_out),
        .data_valid   (data_valid)
    );

    always #5 clk = ~clk;

    // Beats are collected at the falling edge, halfway between two drive edges
    always @(negedge clk) begin
        if (data_valid) begin
            beats.push_back(data_out);
            if (!ready_last) begin
                event_errors++;
                $display("Beat arrived although driver_ready was low in the cycle before");
            end
        end
        ready_last = driver_ready;
    end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            value_errors++;
            $display("** Error: %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    // Expected plane of every lane, built from the layout rule and the plane rule
    function automatic logic [BEAT_W-1:0] expected_beat(input int s, input int c, input int p);
        logic [BEAT_W-1:0] beat;
        pixel_t            px;
        int                b;
        int                idx;
        beat = '0;
        if (p >= PLANES - COLOR_PLANES) begin
            b = p - (PLANES - COLOR_PLANES);
            for (int l = 0; l < NUM_LANES; l++) begin
                for (int k = 0; k < LED_PER_LANE; k++) begin
                    px  = shadow[s * SLICE_WORDS + c * COL_WORDS + l * LED_PER_LANE + k];
                    idx = l * 3 * LED_PER_LANE + 3 * k;
                    beat[idx]     = px[b];
                    beat[idx + 1] = px[COLOR_PLANES + b];
                    beat[idx + 2] = px[2 * COLOR_PLANES + b];
                end
            end
        end
        return beat;
    endfunction

    task automatic apply_reset();
        nrst <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        nrst <= 1'b1;
        @(posedge clk);
        // The slice counter starts again from zero
        exp_slice = 0;
    endtask

    task automatic fill_ram();
        pixel_t px;
        for (int a = 0; a < RAM_WORDS; a++) begin
            px        = pixel_t'($random(seed));
            shadow[a] = px;
            @(posedge clk);
            wr_en   <= 1'b1;
            wr_addr <= ram_addr_t'(a);
            wr_data <= px;
        end
        @(posedge clk);
        wr_en <= 1'b0;
    endtask

    task automatic pulse_sync();
        @(posedge clk);
        position_sync <= 1'b1;
        @(posedge clk);
        position_sync <= 1'b0;
    endtask

    // Optionally toggles driver_ready at random while the beats come in
    task automatic wait_beats(input int count, input bit random_ready);
        int cycles;
        cycles = 0;
        while (beats.size() < count && cycles < BEAT_LIMIT) begin
            @(posedge clk);
            cycles++;
            if (random_ready) begin
                driver_ready <= ($random(seed) % 2 != 0);
            end
        end
        if (beats.size() < count) begin
            event_errors++;
            $display("Timed out waiting for %0d beats, only %0d arrived", count, beats.size());
        end
        driver_ready <= 1'b1;
    endtask

    task automatic check_slice(input int s);
        int idx;
        idx = 0;
        check_value("beat count", beats.size(), SLICE_BEATS);
        for (int c = 0; c < MULTIPLEXING; c++) begin
            for (int p = PLANES - 1; p >= 0; p--) begin
                if (idx < beats.size()) begin
                    check_value($sformatf("data_out slice %0d column %0d plane %0d", s, c, p),
                                beats[idx], expected_beat(s, c, p));
                end
                idx++;
            end
        end
    endtask

    // Sends one slice from a sync pulse and checks it against the model
    task automatic run_slice(input bit random_ready);
        beats.delete();
        pulse_sync();
        wait_beats(SLICE_BEATS, random_ready);
        // Extra cycles show that no beat follows the end of the slice
        repeat (20) @(posedge clk);
        check_slice(exp_slice);
        exp_slice = (exp_slice + 1) % SLICES_IN_RAM;
    endtask

    task automatic check_reset_idle();
        stream_ready <= 1'b1;
        repeat (50) begin
            @(negedge clk);
            check_value("data_valid", data_valid, 1'b0);
            check_value("data_out", data_out, '0);
        end
    endtask

    task automatic send_full_slice();
        fill_ram();
        driver_ready <= 1'b1;
        run_slice(1'b0);
    endtask

    task automatic send_with_backpressure();
        apply_reset();
        run_slice(1'b1);
    endtask

    task automatic rotate_slices();
        apply_reset();
        for (int i = 0; i < SLICES_IN_RAM + 1; i++) begin
            run_slice(1'b0);
        end
    endtask

    task automatic abort_stream();
        beats.delete();
        pulse_sync();
        // Drop the stream somewhere in the second column
        wait_beats(PLANES + 5, 1'b0);
        @(posedge clk);
        stream_ready <= 1'b0;
        // A beat registered at the dropping edge may still show up
        @(posedge clk);
        beats.delete();
        repeat (20) @(posedge clk);
        check_value("beats after abort", beats.size(), 0);
        stream_ready <= 1'b1;
        @(posedge clk);
        // The slice counter is unchanged, so the same slice comes again
        run_slice(1'b0);
    endtask

    initial begin
        clk           = 1'b0;
        nrst          = 1'b0;
        wr_en         = 1'b0;
        wr_addr       = '0;
        wr_data       = '0;
        stream_ready  = 1'b0;
        driver_ready  = 1'b0;
        position_sync = 1'b0;
        ready_last    = 1'b0;
        exp_slice     = 0;
        seed          = 75;
        value_errors  = 0;
        event_errors  = 0;

        apply_reset();
        check_reset_idle();
        send_full_slice();
        send_with_backpressure();
        rotate_slices();
        abort_stream();

        $display("Errors: %0d value mismatches, %0d other failures", value_errors, event_errors);
        if (value_errors == 0 && event_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the tests completed");
        $display("Errors: %0d value mismatches, %0d other failures", value_errors, event_errors);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// File: pov_framebuffer.f
verilog/pov_pkg.sv
verilog/pov_ifs.sv
verilog/slice_ram.sv
verilog/column_fetcher.sv
verilog/pixel_lane.sv
verilog/plane_scheduler.sv
verilog/pov_framebuffer.sv
tests/tb_pov_framebuffer.sv
